// ==== Makefile ====
# Verilator flow for the AXI4 write path
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_axi_wr
RTL_TOP   ?= axi_wr_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axi_burst_writer.sv ====
// AXI4 burst write master
// Accepts a burst command on a valid/ready port, issues AW,
// streams the data port onto W and waits for the B response.
// Reports each finished burst as a one-cycle done pulse.
`timescale 1ns/1ns

module axi_burst_writer (
	input  logic                                clk,
	input  logic                                resetn,

	// Command port
	input  logic                                cmd_valid,
	input  logic [axi_wr_pkg::ADDR_W-1:0]       cmd_addr,
	input  logic [axi_wr_pkg::LEN_W-1:0]        cmd_len,
	input  logic [axi_wr_pkg::SIZE_W-1:0]       cmd_size,
	input  axi_wr_pkg::burst_t                  cmd_burst,
	output logic                                cmd_ready,

	// Data stream port
	input  logic                                data_valid,
	input  logic [axi_wr_pkg::DATA_W-1:0]       data_word,
	output logic                                data_ready,

	// AW channel
	output logic [axi_wr_pkg::ADDR_W-1:0]       awaddr,
	output logic [axi_wr_pkg::LEN_W-1:0]        awlen,
	output logic [axi_wr_pkg::SIZE_W-1:0]       awsize,
	output axi_wr_pkg::burst_t                  awburst,
	output logic                                awvalid,
	input  logic                                awready,

	// W channel
	output logic [axi_wr_pkg::DATA_W-1:0]       wdata,
	output logic                                wlast,
	output logic                                wvalid,
	input  logic                                wready,

	// B channel
	input  axi_wr_pkg::resp_t                   bresp,
	input  logic                                bvalid,
	output logic                                bready,

	// Status
	output logic                                done,
	output axi_wr_pkg::resp_t                   done_resp
);

	axi_wr_pkg::wr_state_t state, state_next;

	logic [axi_wr_pkg::LEN_W-1:0]  beat_cnt;  // Beats sent so far in this burst
	logic                          cmd_fire;
	logic                          beat_fire;

	assign cmd_fire  = cmd_valid && cmd_ready;
	assign beat_fire = wvalid && wready;  // Same cycle as data handshake

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			axi_wr_pkg::WR_IDLE: begin
				if (cmd_fire)
					state_next = axi_wr_pkg::WR_ADDR;
			end
			axi_wr_pkg::WR_ADDR: begin
				if (awvalid && awready)
					state_next = axi_wr_pkg::WR_DATA;
			end
			axi_wr_pkg::WR_DATA: begin
				if (beat_fire && wlast)
					state_next = axi_wr_pkg::WR_RESP;
			end
			axi_wr_pkg::WR_RESP: begin
				if (bvalid && bready)
					state_next = axi_wr_pkg::WR_IDLE;
			end
			default: state_next = axi_wr_pkg::WR_IDLE;
		endcase
	end

	// State, ready flag and beat counter
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state     <= axi_wr_pkg::WR_IDLE;
			cmd_ready <= 1'b0;  // Rises one cycle after reset release
			beat_cnt  <= '0;
		end else begin
			state     <= state_next;
			cmd_ready <= (state_next == axi_wr_pkg::WR_IDLE);
			if (cmd_fire)
				beat_cnt <= '0;  // New burst
			else if (beat_fire)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Command fields held for the AW channel
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			awaddr  <= cmd_addr;
			awlen   <= cmd_len;
			awsize  <= cmd_size;
			awburst <= cmd_burst;
		end
	end

	assign awvalid = (state == axi_wr_pkg::WR_ADDR);

	// W follows the data source, stall on source holds back W
	assign wvalid     = (state == axi_wr_pkg::WR_DATA) && data_valid;
	assign data_ready = (state == axi_wr_pkg::WR_DATA) && wready;
	assign wdata      = data_word;
	assign wlast      = (beat_cnt == awlen);  // Beat L+1

	assign bready    = (state == axi_wr_pkg::WR_RESP);
	assign done      = bvalid && bready;  // Pulse on B handshake
	assign done_resp = bresp;

endmodule

// ==== axi_wr_mem_slave.sv ====
// AXI4 write slave with a word memory
// Latches each AW, checks the whole burst once for errors and
// stores FIXED or INCR full-word beats. Bad bursts are drained
// without writes and answered with SLVERR.
// Also provides a combinational word read port.
`timescale 1ns/1ns

module axi_wr_mem_slave (
	input  logic                                clk,
	input  logic                                resetn,

	// AW channel
	input  logic [axi_wr_pkg::ADDR_W-1:0]       awaddr,
	input  logic [axi_wr_pkg::LEN_W-1:0]        awlen,
	input  logic [axi_wr_pkg::SIZE_W-1:0]       awsize,
	input  axi_wr_pkg::burst_t                  awburst,
	input  logic                                awvalid,
	output logic                                awready,

	// W channel
	input  logic [axi_wr_pkg::DATA_W-1:0]       wdata,
	input  logic                                wlast,
	input  logic                                wvalid,
	output logic                                wready,

	// B channel
	output axi_wr_pkg::resp_t                   bresp,
	output logic                                bvalid,
	input  logic                                bready,

	// Read port
	input  logic [axi_wr_pkg::ADDR_W-1:0]       rd_addr,
	output logic [axi_wr_pkg::DATA_W-1:0]       rd_data
);

	axi_wr_pkg::slv_state_t state, state_next;

	logic [axi_wr_pkg::DATA_W-1:0] mem [axi_wr_pkg::MEM_DEPTH];

	logic [axi_wr_pkg::ADDR_W-1:0] cur_addr;  // Address of the next beat
	axi_wr_pkg::burst_t            cur_burst;
	logic                          err_q;     // Burst rejected
	logic [axi_wr_pkg::ADDR_W:0]   last_addr; // One extra bit for overrun
	logic                          aw_err;
	logic                          aw_fire;
	logic                          w_fire;

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	// Last beat address, FIXED stays at the start
	always_comb begin
		last_addr = {1'b0, awaddr};
		if (awburst == axi_wr_pkg::BURST_INCR)
			last_addr = {1'b0, awaddr}
				+ {{(axi_wr_pkg::ADDR_W + 1 - axi_wr_pkg::LEN_W){1'b0}}, awlen};
	end

	// One error flag for the whole burst
	always_comb begin
		aw_err = 1'b0;
		if (awburst != axi_wr_pkg::BURST_FIXED && awburst != axi_wr_pkg::BURST_INCR)
			aw_err = 1'b1;  // WRAP or reserved
		if (awsize != axi_wr_pkg::SIZE_WORD)
			aw_err = 1'b1;  // Narrow or wide beat
		if (last_addr >= (axi_wr_pkg::ADDR_W + 1)'(axi_wr_pkg::MEM_DEPTH))
			aw_err = 1'b1;  // Runs past memory end
	end

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			axi_wr_pkg::SLV_IDLE: begin
				if (aw_fire)
					state_next = axi_wr_pkg::SLV_DATA;
			end
			axi_wr_pkg::SLV_DATA: begin
				if (w_fire && wlast)
					state_next = axi_wr_pkg::SLV_RESP;
			end
			axi_wr_pkg::SLV_RESP: begin
				if (bvalid && bready)
					state_next = axi_wr_pkg::SLV_IDLE;
			end
			default: state_next = axi_wr_pkg::SLV_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state   <= axi_wr_pkg::SLV_IDLE;
			awready <= 1'b0;  // High from first cycle after reset
			err_q   <= 1'b0;
		end else begin
			state   <= state_next;
			awready <= (state_next == axi_wr_pkg::SLV_IDLE);
			if (aw_fire)
				err_q <= aw_err;
		end
	end

	// Beat address tracking
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			cur_addr  <= awaddr;
			cur_burst <= awburst;
		end else if (w_fire && cur_burst == axi_wr_pkg::BURST_INCR) begin
			cur_addr <= cur_addr + 1'b1;  // Word addressing
		end
	end

	// Memory write, only for accepted bursts
	always_ff @(posedge clk) begin
		if (w_fire && !err_q)
			mem[cur_addr[axi_wr_pkg::MEM_AW-1:0]] <= wdata;
	end

	assign wready = (state == axi_wr_pkg::SLV_DATA);
	assign bvalid = (state == axi_wr_pkg::SLV_RESP);  // Cycle after last beat
	assign bresp  = err_q ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;

	// Out of range reads zero
	assign rd_data = (rd_addr < axi_wr_pkg::ADDR_W'(axi_wr_pkg::MEM_DEPTH))
		? mem[rd_addr[axi_wr_pkg::MEM_AW-1:0]] : '0;

endmodule

// ==== axi_wr_pkg.sv ====
// AXI4 write path shared definitions
// Widths, slave memory depth and the enums for burst type,
// write response and the two FSMs
package axi_wr_pkg;

	localparam int ADDR_W    = 8;   // Word address width
	localparam int DATA_W    = 32;  // Data word width
	localparam int LEN_W     = 8;   // awlen width, L means L+1 beats
	localparam int SIZE_W    = 3;   // awsize width
	localparam int MEM_DEPTH = 64;  // Words in slave memory
	localparam int MEM_AW    = $clog2(MEM_DEPTH);  // Memory index width
	localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;  // 4 bytes per beat

	// AXI burst encodings
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	// AXI response encodings, EXOKAY and DECERR unused
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	// Master FSM
	typedef enum logic [1:0] {
		WR_IDLE,  // Waiting for a command
		WR_ADDR,  // AW valid
		WR_DATA,  // Streaming beats
		WR_RESP   // Waiting on B
	} wr_state_t;

	// Slave FSM
	typedef enum logic [1:0] {
		SLV_IDLE,
		SLV_DATA,
		SLV_RESP
	} slv_state_t;

endpackage

// ==== axi_wr_top.sv ====
// AXI4 write path top level
// Burst writer driving the slave memory over AW, W and B.
// Exposes command, data, done and word read ports.
`timescale 1ns/1ns

module axi_wr_top (
	input  logic                                clk,
	input  logic                                resetn,

	input  logic                                cmd_valid,
	input  logic [axi_wr_pkg::ADDR_W-1:0]       cmd_addr,
	input  logic [axi_wr_pkg::LEN_W-1:0]        cmd_len,
	input  logic [axi_wr_pkg::SIZE_W-1:0]       cmd_size,
	input  axi_wr_pkg::burst_t                  cmd_burst,
	output logic                                cmd_ready,

	input  logic                                data_valid,
	input  logic [axi_wr_pkg::DATA_W-1:0]       data_word,
	output logic                                data_ready,

	output logic                                done,
	output axi_wr_pkg::resp_t                   done_resp,

	input  logic [axi_wr_pkg::ADDR_W-1:0]       rd_addr,
	output logic [axi_wr_pkg::DATA_W-1:0]       rd_data
);

	// AXI channels between master and slave
	logic [axi_wr_pkg::ADDR_W-1:0] awaddr;
	logic [axi_wr_pkg::LEN_W-1:0]  awlen;
	logic [axi_wr_pkg::SIZE_W-1:0] awsize;
	axi_wr_pkg::burst_t            awburst;
	logic                          awvalid, awready;
	logic [axi_wr_pkg::DATA_W-1:0] wdata;
	logic                          wlast, wvalid, wready;
	axi_wr_pkg::resp_t             bresp;
	logic                          bvalid, bready;

	axi_burst_writer u_writer (
		.clk, .resetn,
		.cmd_valid, .cmd_addr, .cmd_len, .cmd_size, .cmd_burst, .cmd_ready,
		.data_valid, .data_word, .data_ready,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wlast, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.done, .done_resp
	);

	axi_wr_mem_slave u_slave (
		.clk, .resetn,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wlast, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.rd_addr, .rd_data
	);

endmodule

// ==== flist.f ====
axi_wr_pkg.sv
axi_burst_writer.sv
axi_wr_mem_slave.sv
axi_wr_top.sv
tb_axi_wr.sv

// ==== tb_axi_wr.sv ====
// Testbench for the AXI4 write path
// Applies a table of bursts with LCG data and random source stalls,
// tracks a reference memory and sweeps the read port after each burst
`timescale 1ns/1ns

module tb_axi_wr;

	localparam int NUM_BURSTS = 8;
	localparam int WAIT_LIMIT = 64;  // Cycles per handshake wait

	typedef struct packed {
		logic [axi_wr_pkg::ADDR_W-1:0] addr;
		logic [axi_wr_pkg::LEN_W-1:0]  len;
		axi_wr_pkg::burst_t            burst;
		logic [axi_wr_pkg::SIZE_W-1:0] size;
		axi_wr_pkg::resp_t             resp;  // Expected B response
	} burst_entry_t;

	logic                          clk, resetn;
	logic                          cmd_valid, cmd_ready;
	logic [axi_wr_pkg::ADDR_W-1:0] cmd_addr;
	logic [axi_wr_pkg::LEN_W-1:0]  cmd_len;
	logic [axi_wr_pkg::SIZE_W-1:0] cmd_size;
	axi_wr_pkg::burst_t            cmd_burst;
	logic                          data_valid, data_ready;
	logic [axi_wr_pkg::DATA_W-1:0] data_word;
	logic                          done;
	axi_wr_pkg::resp_t             done_resp;
	logic [axi_wr_pkg::ADDR_W-1:0] rd_addr;
	logic [axi_wr_pkg::DATA_W-1:0] rd_data;

	burst_entry_t                  bursts [NUM_BURSTS];
	logic [axi_wr_pkg::DATA_W-1:0] mem_model [axi_wr_pkg::MEM_DEPTH];  // Reference memory
	logic [31:0]                   lcg_state;
	int                            done_count;  // Done pulses seen since reset

	axi_wr_top UUT (
		.clk(clk), .resetn(resetn),
		.cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_len(cmd_len),
		.cmd_size(cmd_size), .cmd_burst(cmd_burst), .cmd_ready(cmd_ready),
		.data_valid(data_valid), .data_word(data_word), .data_ready(data_ready),
		.done(done), .done_resp(done_resp),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	// Count done pulses mid-cycle where done is stable
	always @(negedge clk) begin
		if (resetn && done)
			done_count = done_count + 1;
	end

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first failure");
	endtask

	task automatic check_resp(input axi_wr_pkg::resp_t got, input axi_wr_pkg::resp_t exp,
			input int idx);
		if (got !== exp) begin
			$display("error at %0t ns: burst %0d response %b, expected %b",
				$time, idx, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_word(input logic [axi_wr_pkg::DATA_W-1:0] got,
			input logic [axi_wr_pkg::DATA_W-1:0] exp, input int addr);
		if (got !== exp) begin
			$display("error at %0t ns: word %0d reads %h, expected %h",
				$time, addr, got, exp);
			stop_failed();
		end
	endtask

	// Numerical Recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Slave error rules giving one flag for the whole burst
	function automatic logic burst_is_bad(input burst_entry_t e);
		int last_addr;
		last_addr = int'(e.addr);
		if (e.burst == axi_wr_pkg::BURST_INCR)
			last_addr = int'(e.addr) + int'(e.len);
		return (e.burst == axi_wr_pkg::BURST_WRAP) || (e.size != axi_wr_pkg::SIZE_WORD)
			|| (last_addr >= axi_wr_pkg::MEM_DEPTH);
	endfunction

	task automatic send_cmd(input burst_entry_t e);
		int cycles;
		cycles = 0;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_addr  <= e.addr;
		cmd_len   <= e.len;
		cmd_size  <= e.size;
		cmd_burst <= e.burst;
		@(negedge clk);
		while (!cmd_ready && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!cmd_ready) begin
			$display("timeout: cmd_ready stayed low while a command waited");
			stop_failed();
		end else begin
			@(posedge clk);  // Command handshake edge
			cmd_valid <= 1'b0;
		end
	endtask

	// One word per beat with an optional stall before it as the model follows along
	task automatic stream_data(input burst_entry_t e, input logic bad);
		int beat_addr;
		int stall;
		int cycles;
		logic [31:0] r;
		beat_addr = int'(e.addr);
		for (int b = 0; b <= int'(e.len); b++) begin
			r = lcg_next();
			stall = (r[5:4] == 2'b00) ? int'(r[1:0]) + 1 : 0;
			r = lcg_next();
			@(posedge clk);  // Previous handshake edge
			if (stall > 0) begin
				data_valid <= 1'b0;
				repeat (stall) @(posedge clk);
			end
			data_valid <= 1'b1;
			data_word  <= r;
			cycles = 0;
			@(negedge clk);
			while (!data_ready && cycles < WAIT_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (!data_ready) begin
				$display("timeout: data_ready stayed low on beat %0d", b);
				stop_failed();
			end else if (!bad) begin
				mem_model[beat_addr] = r;
				if (e.burst == axi_wr_pkg::BURST_INCR)
					beat_addr++;
			end
		end
		@(posedge clk);  // Last beat handshake
		data_valid <= 1'b0;
	endtask

	task automatic wait_done(input burst_entry_t e, input int idx);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: no done pulse for burst %0d", idx);
			stop_failed();
		end else begin
			check_resp(done_resp, e.resp, idx);
			@(posedge clk);  // B handshake edge
			if (done_count != idx + 1) begin
				$display("burst %0d gave %0d done pulses in total, not one each", idx, done_count);
				stop_failed();
			end
		end
	endtask

	// Whole memory against the model and optionally a few addresses past the end
	task automatic sweep_mem(input logic with_oob);
		for (int a = 0; a < axi_wr_pkg::MEM_DEPTH; a++) begin
			@(posedge clk);
			rd_addr <= a[axi_wr_pkg::ADDR_W-1:0];
			@(negedge clk);
			check_word(rd_data, mem_model[a], a);
		end
		if (with_oob) begin
			for (int a = axi_wr_pkg::MEM_DEPTH; a < 256; a += 63) begin
				@(posedge clk);
				rd_addr <= a[axi_wr_pkg::ADDR_W-1:0];
				@(negedge clk);
				check_word(rd_data, '0, a);
			end
		end
	endtask

	task automatic load_bursts();
		// addr, len, burst, size, expected response
		bursts[0] = '{8'd0,  8'd63, axi_wr_pkg::BURST_INCR,  3'd2, axi_wr_pkg::RESP_OKAY};   // Fill all
		bursts[1] = '{8'd5,  8'd0,  axi_wr_pkg::BURST_INCR,  3'd2, axi_wr_pkg::RESP_OKAY};   // One beat
		bursts[2] = '{8'd10, 8'd15, axi_wr_pkg::BURST_INCR,  3'd2, axi_wr_pkg::RESP_OKAY};   // 16 beats
		bursts[3] = '{8'd60, 8'd3,  axi_wr_pkg::BURST_INCR,  3'd2, axi_wr_pkg::RESP_OKAY};   // Ends at 63
		bursts[4] = '{8'd62, 8'd3,  axi_wr_pkg::BURST_INCR,  3'd2, axi_wr_pkg::RESP_SLVERR}; // Overrun
		bursts[5] = '{8'd30, 8'd3,  axi_wr_pkg::BURST_FIXED, 3'd2, axi_wr_pkg::RESP_OKAY};
		bursts[6] = '{8'd40, 8'd3,  axi_wr_pkg::BURST_WRAP,  3'd2, axi_wr_pkg::RESP_SLVERR};
		bursts[7] = '{8'd20, 8'd1,  axi_wr_pkg::BURST_INCR,  3'd1, axi_wr_pkg::RESP_SLVERR}; // Narrow
	endtask

	initial begin
		int cycles;
		resetn     = 1'b0;
		cmd_valid  = 1'b0;
		cmd_addr   = '0;
		cmd_len    = '0;
		cmd_size   = '0;
		cmd_burst  = axi_wr_pkg::BURST_FIXED;
		data_valid = 1'b0;
		data_word  = '0;
		rd_addr    = '0;
		lcg_state  = 32'h93e2;
		done_count = 0;
		for (int a = 0; a < axi_wr_pkg::MEM_DEPTH; a++)
			mem_model[a] = '0;  // Overwritten by the first burst
		load_bursts();
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!cmd_ready && cycles < 4) begin
			@(negedge clk);
			cycles++;
		end
		if (!cmd_ready || done_count != 0) begin
			$display("after reset cmd_ready did not rise or done pulsed early");
			stop_failed();
		end
		for (int i = 0; i < NUM_BURSTS; i++) begin
			send_cmd(bursts[i]);
			stream_data(bursts[i], burst_is_bad(bursts[i]));
			wait_done(bursts[i], i);
			sweep_mem(1'b0);  // Bad bursts must leave memory unchanged
		end
		sweep_mem(1'b1);
		repeat (4) @(posedge clk);
		if (done_count == NUM_BURSTS) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("saw %0d done pulses for %0d bursts", done_count, NUM_BURSTS);
			stop_failed();
		end
	end

endmodule
